/* rv_core.f */
hdl/rv_pkg.sv
hdl/rv_idu.sv
hdl/rv_exu.sv
hdl/rv_regfile.sv
hdl/rv_ctrl.sv
hdl/rv_apb_master.sv
hdl/rv_core.sv
tb/rv_core_asserts.sv
tb/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the rv_core testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module rv_core_tb -f rv_core.f \
    --Mdir obj_dir -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/rv_core_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
echo "Pass message not found"
exit 1

/* tb/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

    localparam int NUM_TESTS    = 6;
    localparam int PROG_WORDS   = 12;
    localparam int MEM_WORDS    = 256;
    localparam int RESET_CYCLES = 8;
    localparam int HALT_TIMEOUT = 2000;
    // Word index of data address 0x200.
    localparam logic [7:0] DATA_IDX = 8'd128;

    logic        clk;
    logic        rst_n;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
    logic [31:0] prdata;
    logic        pready;
    logic        halted;
    logic [31:0] halt_code;
    logic        illegal;

    // APB slave memory and its wait-state source.
    logic [31:0] mem [MEM_WORDS];
    logic [15:0] lfsr;
    logic [1:0]  wait_left;
    logic        stall_on;

    // Program table with one row per test.
    string       test_name [NUM_TESTS];
    logic [31:0] test_prog [NUM_TESTS][PROG_WORDS];
    logic [31:0] exp_code  [NUM_TESTS];
    logic        exp_ill   [NUM_TESTS];
    logic [31:0] exp_mem   [NUM_TESTS];

    rv_core rv_core_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .prdata    (prdata),
        .pready    (pready),
        .halted    (halted),
        .halt_code (halt_code),
        .illegal   (illegal)
    );

    always #10 clk = ~clk;

    // One instruction encoder per RV32I format.
    function automatic logic [31:0] r_word(input logic [6:0] funct7, input int rs2,
                                           input int rs1, input logic [2:0] funct3,
                                           input int rd);
        return {funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], rv_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] i_word(input logic [6:0] opcode, input int imm,
                                           input int rs1, input logic [2:0] funct3,
                                           input int rd);
        return {imm[11:0], rs1[4:0], funct3, rd[4:0], opcode};
    endfunction

    function automatic logic [31:0] s_word(input int imm, input int rs2, input int rs1,
                                           input logic [2:0] funct3);
        return {imm[11:5], rs2[4:0], rs1[4:0], funct3, imm[4:0], rv_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] u_word(input logic [6:0] opcode, input int imm20,
                                           input int rd);
        return {imm20[19:0], rd[4:0], opcode};
    endfunction

    // J offset is scrambled as imm[20|10:1|11|19:12].
    function automatic logic [31:0] j_word(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_pkg::OPC_JAL};
    endfunction

    // Fibonacci LFSR with taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected 0x%08h, actual 0x%08h",
                     name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input string what,
                              input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s %s: expected %0b, actual %0b", name, what, expected, actual);
            abort_run();
        end
    endtask

    // One falling edge of the APB slave.
    task automatic serve_apb();
        logic [7:0] idx;
        idx    = paddr[9:2];
        pready = 1'b0;
        if (psel && !penable) begin
            // Fetch and data addresses are always whole words.
            if (paddr[1:0] !== 2'b00) begin
                $display("APB transfer started at unaligned address 0x%08h", paddr);
                abort_run();
            end
            // Setup phase picks 0 to 3 wait states with one LFSR step per bit.
            wait_left = 2'd0;
            if (stall_on) begin
                lfsr         = lfsr_next(lfsr);
                wait_left[0] = lfsr[0];
                lfsr         = lfsr_next(lfsr);
                wait_left[1] = lfsr[0];
            end
        end else if (psel && penable) begin
            if (wait_left == 2'd0) begin
                pready = 1'b1;
                prdata = mem[idx];
                if (pwrite) begin
                    for (int b = 0; b < 4; b++) begin
                        if (pstrb[b]) begin
                            mem[idx][8*b +: 8] = pwdata[8*b +: 8];
                        end
                    end
                end
            end else begin
                wait_left = wait_left - 2'd1;
            end
        end
    endtask

    task automatic set_row(input int t, input string name, input logic [31:0] code,
                           input logic ill, input logic [31:0] word);
        test_name[t] = name;
        exp_code[t]  = code;
        exp_ill[t]   = ill;
        exp_mem[t]   = word;
    endtask

    task automatic build_table();
        // Immediate and register arithmetic ending in a0 = 0x70 + sltu.
        set_row(0, "alu_ops", 32'h0000_0071, 1'b0, 32'h0);
        test_prog[0] = '{
            i_word(rv_pkg::OPC_OPIMM, 100, 0, rv_pkg::ALU_ADD, 1),
            i_word(rv_pkg::OPC_OPIMM, -7, 0, rv_pkg::ALU_ADD, 2),
            r_word(7'h20, 2, 1, rv_pkg::ALU_ADD, 3),
            r_word(7'h00, 1, 2, rv_pkg::ALU_SLT, 4),
            r_word(7'h00, 2, 1, rv_pkg::ALU_SLTU, 5),
            r_word(7'h00, 2, 3, rv_pkg::ALU_XOR, 6),
            i_word(rv_pkg::OPC_OPIMM, 32'h404, 6, rv_pkg::ALU_SR, 7),
            r_word(7'h00, 1, 7, rv_pkg::ALU_AND, 8),
            r_word(7'h00, 1, 4, rv_pkg::ALU_SLL, 9),
            r_word(7'h00, 9, 8, rv_pkg::ALU_OR, 10),
            r_word(7'h00, 5, 10, rv_pkg::ALU_ADD, 10),
            rv_pkg::EBREAK_WORD
        };
        // Shifts of a negative value, then immediate logic ops.
        set_row(1, "shift_ops", 32'h1000_037C, 1'b0, 32'h0);
        test_prog[1] = '{
            u_word(rv_pkg::OPC_LUI, 32'h80000, 1),
            i_word(rv_pkg::OPC_OPIMM, 3, 0, rv_pkg::ALU_ADD, 2),
            r_word(7'h20, 2, 1, rv_pkg::ALU_SR, 3),
            r_word(7'h00, 2, 1, rv_pkg::ALU_SR, 4),
            i_word(rv_pkg::OPC_OPIMM, 24, 3, rv_pkg::ALU_SR, 5),
            i_word(rv_pkg::OPC_OPIMM, 8, 2, rv_pkg::ALU_SLL, 6),
            i_word(rv_pkg::OPC_OPIMM, 15, 5, rv_pkg::ALU_XOR, 7),
            i_word(rv_pkg::OPC_OPIMM, 32'h40, 6, rv_pkg::ALU_OR, 8),
            i_word(rv_pkg::OPC_OPIMM, 32'h3C, 7, rv_pkg::ALU_AND, 9),
            r_word(7'h00, 8, 4, rv_pkg::ALU_ADD, 10),
            r_word(7'h00, 9, 10, rv_pkg::ALU_ADD, 10),
            rv_pkg::EBREAK_WORD
        };
        // a0 = lui + auipc(0x04) + jal link 0x0C + jalr link 0x18.
        set_row(2, "upper_jump", 32'h1234_6028, 1'b0, 32'h0);
        test_prog[2] = '{
            u_word(rv_pkg::OPC_LUI, 32'h12345, 1),
            u_word(rv_pkg::OPC_AUIPC, 1, 2),
            j_word(12, 3),
            i_word(rv_pkg::OPC_OPIMM, -1, 0, rv_pkg::ALU_ADD, 10),
            i_word(rv_pkg::OPC_OPIMM, -1, 0, rv_pkg::ALU_ADD, 10),
            i_word(rv_pkg::OPC_JALR, 17, 3, 3'd0, 4),
            i_word(rv_pkg::OPC_OPIMM, -1, 0, rv_pkg::ALU_ADD, 10),
            r_word(7'h00, 2, 1, rv_pkg::ALU_ADD, 10),
            r_word(7'h00, 3, 10, rv_pkg::ALU_ADD, 10),
            r_word(7'h00, 4, 10, rv_pkg::ALU_ADD, 10),
            rv_pkg::EBREAK_WORD,
            32'h0
        };
        // SW, then SB at byte 1, SH at byte 2, SB at byte 3.
        set_row(3, "stores", 32'h7EFF_55D4, 1'b0, 32'h7EFF_55D4);
        test_prog[3] = '{
            i_word(rv_pkg::OPC_OPIMM, 32'h200, 0, rv_pkg::ALU_ADD, 1),
            u_word(rv_pkg::OPC_LUI, 32'hA1B2C, 2),
            i_word(rv_pkg::OPC_OPIMM, 32'h3D4, 2, rv_pkg::ALU_ADD, 2),
            s_word(0, 2, 1, 3'd2),
            i_word(rv_pkg::OPC_OPIMM, 32'h55, 0, rv_pkg::ALU_ADD, 3),
            s_word(1, 3, 1, 3'd0),
            i_word(rv_pkg::OPC_OPIMM, -1, 0, rv_pkg::ALU_ADD, 4),
            s_word(2, 4, 1, 3'd1),
            i_word(rv_pkg::OPC_OPIMM, 32'h7E, 0, rv_pkg::ALU_ADD, 5),
            s_word(3, 5, 1, 3'd0),
            i_word(rv_pkg::OPC_LOAD, 0, 1, 3'd2, 10),
            rv_pkg::EBREAK_WORD
        };
        // Data word sits at 0x2C; LBU takes bytes 1 and 3.
        set_row(4, "loads", 32'h0000_9CE5, 1'b0, 32'h9C3A_E517);
        test_prog[4] = '{
            i_word(rv_pkg::OPC_LOAD, 44, 0, 3'd2, 1),
            i_word(rv_pkg::OPC_LOAD, 45, 0, 3'd4, 2),
            i_word(rv_pkg::OPC_LOAD, 47, 0, 3'd4, 3),
            i_word(rv_pkg::OPC_OPIMM, 8, 3, rv_pkg::ALU_SLL, 3),
            r_word(7'h00, 3, 2, rv_pkg::ALU_OR, 10),
            s_word(32'h200, 1, 0, 3'd2),
            rv_pkg::EBREAK_WORD,
            32'h0,
            32'h0,
            32'h0,
            32'h0,
            32'h9C3A_E517
        };
        // Custom-0 opcode stops the core before the store.
        set_row(5, "illegal", 32'h0, 1'b1, 32'h0);
        test_prog[5] = '{
            i_word(rv_pkg::OPC_OPIMM, 32'h123, 0, rv_pkg::ALU_ADD, 10),
            i_word(rv_pkg::OPC_OPIMM, 32'h200, 0, rv_pkg::ALU_ADD, 1),
            32'h0000_000B,
            s_word(0, 10, 1, 3'd2),
            rv_pkg::EBREAK_WORD,
            32'h0,
            32'h0,
            32'h0,
            32'h0,
            32'h0,
            32'h0,
            32'h0
        };
    endtask

    task automatic run_test(input int t);
        string name;
        int    cycles;
        name = stall_on ? {test_name[t], "_stall"} : test_name[t];
        @(negedge clk);
        rst_n = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'h0;
        end
        for (int i = 0; i < PROG_WORDS; i++) begin
            mem[i] = test_prog[t][i];
        end
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            serve_apb();
        end
        rst_n  = 1'b1;
        cycles = 0;
        // Serve the bus until the core halts.
        while (halted !== 1'b1) begin
            if (cycles >= HALT_TIMEOUT) begin
                $display("core did not halt in test %s after %0d cycles", name, cycles);
                abort_run();
            end
            @(negedge clk);
            serve_apb();
            cycles++;
        end
        check_word(name, "halt_code", exp_code[t], halt_code);
        check_flag(name, "illegal", exp_ill[t], illegal);
        check_word(name, "mem[0x200]", exp_mem[t], mem[DATA_IDX]);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        prdata    = 32'h0;
        pready    = 1'b0;
        lfsr      = 16'd68;
        wait_left = 2'd0;
        stall_on  = 1'b0;
        build_table();
        // First pass without wait states and second pass with random stalls.
        for (int pass = 0; pass < 2; pass++) begin
            stall_on = (pass == 1);
            for (int t = 0; t < NUM_TESTS; t++) begin
                run_test(t);
            end
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

/* tb/rv_core_asserts.sv */
`timescale 1ns/1ps

module rv_core_asserts (
    input logic        clk,
    input logic        rst_n,
    input logic [31:0] paddr,
    input logic        psel,
    input logic        penable,
    input logic        pwrite,
    input logic [31:0] pwdata,
    input logic [3:0]  pstrb,
    input logic        pready,
    input logic        halted
);

    // Access phase only after a selected cycle.
    penable_after_psel: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel && $past(psel))
        else $error("penable high without a preceding setup phase");

    // A stalled access holds every request signal.
    stable_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable && !pready) |=> psel && penable && $stable(paddr) &&
        $stable(pwrite) && $stable(pwdata) && $stable(pstrb))
        else $error("APB signals changed during a stalled access");

    // No transfer once halted.
    idle_when_halted: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !psel)
        else $error("psel high while the core is halted");

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
        else $error("halted dropped without reset");

endmodule

bind rv_core rv_core_asserts rv_core_asserts_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .pready  (pready),
    .halted  (halted)
);

/* hdl/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] paddr,
    output logic        psel,
    output logic        penable,
    output logic        pwrite,
    output logic [31:0] pwdata,
    output logic [3:0]  pstrb,
    input  logic [31:0] prdata,
    input  logic        pready,
    output logic        halted,
    output logic [31:0] halt_code,
    output logic        illegal
);

    logic [rv_pkg::OPT_W-1:0] opt;
    rv_pkg::insn_t            insn;
    logic [31:0]              imm;
    logic [31:0]              pc;
    logic [4:0]               rs1;
    logic [4:0]               rs2;
    logic [4:0]               rd;
    logic [31:0]              rs1_d;
    logic [31:0]              rs2_d;
    logic [31:0]              res;
    logic [31:0]              dnpc;
    logic [31:0]              mem_wdata;
    logic [3:0]               mem_strb;
    logic                     ebreak;
    logic                     req;
    logic [31:0]              addr;
    logic                     write;
    logic [31:0]              wdata;
    logic [3:0]               strb;
    logic                     done;
    logic [31:0]              rdata;
    logic                     we;
    logic [4:0]               waddr;
    logic [31:0]              wb_data;

    rv_ctrl rv_ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .opt       (opt),
        .rd        (rd),
        .res       (res),
        .dnpc      (dnpc),
        .mem_wdata (mem_wdata),
        .mem_strb  (mem_strb),
        .ebreak    (ebreak),
        .rs1_d     (rs1_d),
        .pc        (pc),
        .insn      (insn),
        .req       (req),
        .addr      (addr),
        .write     (write),
        .wdata     (wdata),
        .strb      (strb),
        .done      (done),
        .rdata     (rdata),
        .we        (we),
        .waddr     (waddr),
        .wb_data   (wb_data),
        .halted    (halted),
        .halt_code (halt_code),
        .illegal   (illegal)
    );

    rv_idu rv_idu_i (
        .insn (insn),
        .opt  (opt),
        .imm  (imm),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd)
    );

    rv_exu rv_exu_i (
        .opt       (opt),
        .rs1_d     (rs1_d),
        .rs2_d     (rs2_d),
        .imm       (imm),
        .pc        (pc),
        .res       (res),
        .dnpc      (dnpc),
        .mem_wdata (mem_wdata),
        .mem_strb  (mem_strb),
        .ebreak    (ebreak)
    );

    rv_regfile rv_regfile_i (
        .clk   (clk),
        .rst_n (rst_n),
        .rs1   (rs1),
        .rs2   (rs2),
        .rs1_d (rs1_d),
        .rs2_d (rs2_d),
        .we    (we),
        .waddr (waddr),
        .wdata (wb_data)
    );

    rv_apb_master rv_apb_master_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .addr    (addr),
        .write   (write),
        .wdata   (wdata),
        .strb    (strb),
        .done    (done),
        .rdata   (rdata),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready)
    );

endmodule

/* hdl/rv_apb_master.sv */
`timescale 1ns/1ps

module rv_apb_master (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req,
    input  logic [31:0] addr,
    input  logic        write,
    input  logic [31:0] wdata,
    input  logic [3:0]  strb,
    output logic        done,
    output logic [31:0] rdata,
    output logic [31:0] paddr,
    output logic        psel,
    output logic        penable,
    output logic        pwrite,
    output logic [31:0] pwdata,
    output logic [3:0]  pstrb,
    input  logic [31:0] prdata,
    input  logic        pready
);

    logic start;

    // New transfer only from idle.
    assign start = req & ~psel;

    // Setup, then access until pready.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            psel    <= 1'b0;
            penable <= 1'b0;
        end else if (start) begin
            psel <= 1'b1;
        end else if (psel && !penable) begin
            penable <= 1'b1;
        end else if (psel && pready) begin
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    end

    // Request fields held for the whole transfer.
    always_ff @(posedge clk) begin
        if (start) begin
            paddr  <= addr;
            pwrite <= write;
            pwdata <= wdata;
            pstrb  <= write ? strb : 4'h0;
        end
    end

    assign done  = psel & penable & pready;
    assign rdata = prdata;

endmodule

/* hdl/rv_ctrl.sv */
`timescale 1ns/1ps

module rv_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [rv_pkg::OPT_W-1:0] opt,
    input  logic [4:0]               rd,
    input  logic [31:0]              res,
    input  logic [31:0]              dnpc,
    input  logic [31:0]              mem_wdata,
    input  logic [3:0]               mem_strb,
    input  logic                     ebreak,
    input  logic [31:0]              rs1_d,
    output logic [31:0]              pc,
    output rv_pkg::insn_t            insn,
    output logic                     req,
    output logic [31:0]              addr,
    output logic                     write,
    output logic [31:0]              wdata,
    output logic [3:0]               strb,
    input  logic                     done,
    input  logic [31:0]              rdata,
    output logic                     we,
    output logic [4:0]               waddr,
    output logic [31:0]              wb_data,
    output logic                     halted,
    output logic [31:0]              halt_code,
    output logic                     illegal
);

    logic [1:0]  state;
    logic [1:0]  width;
    logic        mem_op;
    logic        is_load;
    logic        in_exec;
    logic        in_mem;
    logic [7:0]  load_byte;
    logic [31:0] load_data;

    assign width   = opt[rv_pkg::OPT_WIDTH +: 2];
    assign mem_op  = |width;
    assign is_load = opt[rv_pkg::OPT_LOAD];
    assign in_exec = (state == rv_pkg::ST_EXEC);
    assign in_mem  = (state == rv_pkg::ST_MEM);

    // Bus request, held until done.
    assign req   = (state == rv_pkg::ST_FETCH) | in_mem;
    assign addr  = in_mem ? {res[31:2], 2'b00} : pc;
    assign write = in_mem & ~is_load;
    assign wdata = mem_wdata;
    assign strb  = mem_strb;

    // LBU picks one lane and zero-extends.
    assign load_byte = rdata[{res[1:0], 3'b000} +: 8];
    assign load_data = (width == 2'd1) ? {24'h0, load_byte} : rdata;

    // Writeback in EXEC for ALU ops, at the end of MEM for loads.
    assign we = (in_exec & opt[rv_pkg::OPT_WB] & ~mem_op & ~opt[rv_pkg::OPT_ILLEGAL]) |
                (in_mem & done & is_load);
    assign waddr   = rd;
    assign wb_data = in_mem ? load_data : res;

    assign halted = (state == rv_pkg::ST_HALT);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= rv_pkg::ST_FETCH;
            pc        <= rv_pkg::RESET_PC;
            illegal   <= 1'b0;
            halt_code <= '0;
        end else begin
            case (state)
                rv_pkg::ST_FETCH: begin
                    if (done) begin
                        state <= rv_pkg::ST_EXEC;
                    end
                end
                rv_pkg::ST_EXEC: begin
                    if (opt[rv_pkg::OPT_ILLEGAL]) begin
                        illegal <= 1'b1;
                        state   <= rv_pkg::ST_HALT;
                    end else if (ebreak) begin
                        // a0 arrives on rs1_d.
                        halt_code <= rs1_d;
                        state     <= rv_pkg::ST_HALT;
                    end else begin
                        pc    <= dnpc;
                        state <= mem_op ? rv_pkg::ST_MEM : rv_pkg::ST_FETCH;
                    end
                end
                rv_pkg::ST_MEM: begin
                    if (done) begin
                        state <= rv_pkg::ST_FETCH;
                    end
                end
                default: begin
                    // Stay halted until reset.
                    state <= rv_pkg::ST_HALT;
                end
            endcase
        end
    end

    // Instruction register.
    always_ff @(posedge clk) begin
        if ((state == rv_pkg::ST_FETCH) && done) begin
            insn <= rdata;
        end
    end

endmodule

/* hdl/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rs1_d,
    output logic [31:0] rs2_d,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [32];

    // All registers clear on reset, x0 is never written.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Asynchronous reads, x0 reads as zero.
    assign rs1_d = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_d = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* hdl/rv_exu.sv */
`timescale 1ns/1ps

module rv_exu (
    input  logic [rv_pkg::OPT_W-1:0] opt,
    input  logic [31:0]              rs1_d,
    input  logic [31:0]              rs2_d,
    input  logic [31:0]              imm,
    input  logic [31:0]              pc,
    output logic [31:0]              res,
    output logic [31:0]              dnpc,
    output logic [31:0]              mem_wdata,
    output logic [3:0]               mem_strb,
    output logic                     ebreak
);

    logic [1:0]  arg_sel;
    logic [1:0]  pc_sel;
    logic [1:0]  width;
    logic [2:0]  alu_fn;
    logic        sub;
    logic        link;
    logic [31:0] var1;
    logic [31:0] var2;
    logic [31:0] arg2;
    logic [4:0]  shamt;
    logic [31:0] ina;
    logic [31:0] inb;
    logic [31:0] npc_sum;
    logic [3:0]  base_mask;

    assign arg_sel = opt[rv_pkg::OPT_ARG +: 2];
    assign alu_fn  = opt[rv_pkg::OPT_ALU +: 3];
    assign sub     = opt[rv_pkg::OPT_SUB];
    assign pc_sel  = opt[rv_pkg::OPT_PC +: 2];
    assign width   = opt[rv_pkg::OPT_WIDTH +: 2];

    // Jumps write pc + 4 to rd.
    assign link = pc_sel[1];

    // ALU operand pair.
    always_comb begin
        case (arg_sel)
            2'd0:    {var1, arg2} = {imm, 32'h0};
            2'd1:    {var1, arg2} = {pc, imm};
            2'd2:    {var1, arg2} = {rs1_d, rs2_d};
            default: {var1, arg2} = {rs1_d, imm};
        endcase
    end

    assign var2  = link ? 32'd4 : arg2;
    assign shamt = var2[4:0];

    // ALU result, also the load/store address.
    always_comb begin
        case (alu_fn)
            rv_pkg::ALU_ADD:  res = sub ? var1 - var2 : var1 + var2;
            rv_pkg::ALU_SLL:  res = var1 << shamt;
            rv_pkg::ALU_SLT:  res = {31'h0, $signed(var1) < $signed(var2)};
            rv_pkg::ALU_SLTU: res = {31'h0, var1 < var2};
            rv_pkg::ALU_XOR:  res = var1 ^ var2;
            rv_pkg::ALU_SR:   res = sub ? 32'($signed(var1) >>> shamt) : var1 >> shamt;
            rv_pkg::ALU_OR:   res = var1 | var2;
            default:          res = var1 & var2;
        endcase
    end

    // Next-PC pair, with its own adder.
    always_comb begin
        case (pc_sel)
            2'd2:    {ina, inb} = {pc, imm};
            2'd3:    {ina, inb} = {rs1_d, imm};
            default: {ina, inb} = {pc, 32'd4};
        endcase
    end

    assign npc_sum = ina + inb;
    // JALR clears bit 0 of the target.
    assign dnpc = {npc_sum[31:1], npc_sum[0] & (pc_sel != 2'd3)};

    // Byte strobe, shifted to the addressed lane.
    always_comb begin
        case (width)
            2'd1:    base_mask = 4'b0001;
            2'd2:    base_mask = 4'b0011;
            2'd3:    base_mask = 4'b1111;
            default: base_mask = 4'b0000;
        endcase
    end

    assign mem_strb = base_mask << res[1:0];

    // Store data repeated on every lane it could land on.
    always_comb begin
        case (width)
            2'd1:    mem_wdata = {4{rs2_d[7:0]}};
            2'd2:    mem_wdata = {2{rs2_d[15:0]}};
            default: mem_wdata = rs2_d;
        endcase
    end

    assign ebreak = opt[rv_pkg::OPT_EBREAK];

endmodule

/* hdl/rv_idu.sv */
`timescale 1ns/1ps

module rv_idu (
    input  rv_pkg::insn_t             insn,
    output logic [rv_pkg::OPT_W-1:0]  opt,
    output logic [31:0]               imm,
    output logic [4:0]                rs1,
    output logic [4:0]                rs2,
    output logic [4:0]                rd
);

    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [2:0]  funct3;
    logic        alt;
    logic        is_ebreak;

    assign funct3 = insn.r_fmt.funct3;
    // Bit 30 marks sub and sra.
    assign alt    = insn.r_fmt.funct7[5];

    // Sign-extended immediates.
    assign imm_i = {{20{insn.i_fmt.imm12[11]}}, insn.i_fmt.imm12};
    assign imm_s = {{20{insn.s_fmt.imm_hi[6]}}, insn.s_fmt.imm_hi, insn.s_fmt.imm_lo};
    assign imm_u = {insn.u_fmt.imm20, 12'h000};
    // J layout is imm[20|10:1|11|19:12] in the upper 20 bits.
    assign imm_j = {{11{insn.u_fmt.imm20[19]}}, insn.u_fmt.imm20[19],
                    insn.u_fmt.imm20[7:0], insn.u_fmt.imm20[8],
                    insn.u_fmt.imm20[18:9], 1'b0};

    assign is_ebreak = (insn == rv_pkg::EBREAK_WORD);

    // EBREAK reads a0 so that the halt code comes out on rs1_d.
    assign rs1 = is_ebreak ? 5'd10 : insn.r_fmt.rs1;
    assign rs2 = insn.r_fmt.rs2;
    assign rd  = insn.r_fmt.rd;

    always_comb begin
        opt = '0;
        imm = '0;
        opt[rv_pkg::OPT_ALU +: 3] = rv_pkg::ALU_ADD;
        case (insn.r_fmt.opcode)
            rv_pkg::OPC_LUI: begin
                // imm + 0.
                opt[rv_pkg::OPT_WB] = 1'b1;
                imm = imm_u;
            end
            rv_pkg::OPC_AUIPC: begin
                opt[rv_pkg::OPT_ARG +: 2] = 2'd1;
                opt[rv_pkg::OPT_WB]       = 1'b1;
                imm = imm_u;
            end
            rv_pkg::OPC_JAL: begin
                // Link comes from pc + 4 on the ALU.
                opt[rv_pkg::OPT_ARG +: 2] = 2'd1;
                opt[rv_pkg::OPT_PC +: 2]  = 2'd2;
                opt[rv_pkg::OPT_WB]       = 1'b1;
                imm = imm_j;
            end
            rv_pkg::OPC_JALR: begin
                opt[rv_pkg::OPT_ARG +: 2] = 2'd1;
                opt[rv_pkg::OPT_PC +: 2]  = 2'd3;
                opt[rv_pkg::OPT_WB]       = 1'b1;
                opt[rv_pkg::OPT_ILLEGAL]  = (funct3 != 3'd0);
                imm = imm_i;
            end
            rv_pkg::OPC_LOAD: begin
                opt[rv_pkg::OPT_ARG +: 2] = 2'd3;
                opt[rv_pkg::OPT_LOAD]     = 1'b1;
                opt[rv_pkg::OPT_WB]       = 1'b1;
                imm = imm_i;
                // Only LW and LBU.
                case (funct3)
                    3'd2:    opt[rv_pkg::OPT_WIDTH +: 2] = 2'd3;
                    3'd4:    opt[rv_pkg::OPT_WIDTH +: 2] = 2'd1;
                    default: opt[rv_pkg::OPT_ILLEGAL]    = 1'b1;
                endcase
            end
            rv_pkg::OPC_STORE: begin
                opt[rv_pkg::OPT_ARG +: 2] = 2'd3;
                imm = imm_s;
                if (funct3 <= 3'd2) begin
                    opt[rv_pkg::OPT_WIDTH +: 2] = funct3[1:0] + 2'd1;
                end else begin
                    opt[rv_pkg::OPT_ILLEGAL] = 1'b1;
                end
            end
            rv_pkg::OPC_OPIMM: begin
                opt[rv_pkg::OPT_ARG +: 2] = 2'd3;
                opt[rv_pkg::OPT_ALU +: 3] = funct3;
                // No subi, so only srai uses the alt bit.
                opt[rv_pkg::OPT_SUB]      = alt & (funct3 == rv_pkg::ALU_SR);
                opt[rv_pkg::OPT_WB]       = 1'b1;
                imm = imm_i;
            end
            rv_pkg::OPC_OP: begin
                opt[rv_pkg::OPT_ARG +: 2] = 2'd2;
                opt[rv_pkg::OPT_ALU +: 3] = funct3;
                opt[rv_pkg::OPT_SUB]      = alt & ((funct3 == rv_pkg::ALU_ADD) ||
                                                   (funct3 == rv_pkg::ALU_SR));
                opt[rv_pkg::OPT_WB]       = 1'b1;
            end
            rv_pkg::OPC_SYSTEM: begin
                // Only EBREAK; ECALL and CSRs trap as illegal.
                opt[rv_pkg::OPT_EBREAK]  = is_ebreak;
                opt[rv_pkg::OPT_ILLEGAL] = ~is_ebreak;
            end
            default: begin
                opt[rv_pkg::OPT_ILLEGAL] = 1'b1;
            end
        endcase
    end

endmodule

/* hdl/rv_pkg.sv */
package rv_pkg;

    // Control word width.
    localparam int OPT_W = 14;

    // Control word fields, given as the low bit of each field.
    localparam int OPT_ILLEGAL = 0;
    localparam int OPT_EBREAK  = 1;
    localparam int OPT_WB      = 2;
    // Two bits, ALU operand pair.
    localparam int OPT_ARG     = 3;
    // Three bits, ALU function.
    localparam int OPT_ALU     = 5;
    // Two bits, next-PC operand pair.
    localparam int OPT_PC      = 8;
    // Two bits, access width.
    localparam int OPT_WIDTH   = 10;
    localparam int OPT_LOAD    = 12;
    localparam int OPT_SUB     = 13;

    // ALU functions, numbered as funct3.
    localparam logic [2:0] ALU_ADD  = 3'd0;
    localparam logic [2:0] ALU_SLL  = 3'd1;
    localparam logic [2:0] ALU_SLT  = 3'd2;
    localparam logic [2:0] ALU_SLTU = 3'd3;
    localparam logic [2:0] ALU_XOR  = 3'd4;
    localparam logic [2:0] ALU_SR   = 3'd5;
    localparam logic [2:0] ALU_OR   = 3'd6;
    localparam logic [2:0] ALU_AND  = 3'd7;

    // Major opcodes.
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // Sequencer states.
    localparam logic [1:0] ST_FETCH = 2'd0;
    localparam logic [1:0] ST_EXEC  = 2'd1;
    localparam logic [1:0] ST_MEM   = 2'd2;
    localparam logic [1:0] ST_HALT  = 2'd3;

    localparam logic [31:0] RESET_PC    = 32'h0000_0000;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    // One instruction word seen through its four encodings.
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
    } insn_t;

endpackage
